// File: flist.f
rtl/mac_arith_pkg.sv
rtl/mac_regs_pkg.sv
rtl/packed_mac.sv
rtl/pe_engine.sv
rtl/mem_arbiter.sv
rtl/pixel_mem.sv
rtl/apb_regs.sv
rtl/bnn_mac_top.sv
testbench/tb_clock.sv
testbench/tb_bnn_mac.sv

// File: Bender.yml
package:
  name: bnn_mac

sources:
  - files:
      - rtl/mac_arith_pkg.sv
      - rtl/mac_regs_pkg.sv
      - rtl/packed_mac.sv
      - rtl/pe_engine.sv
      - rtl/mem_arbiter.sv
      - rtl/pixel_mem.sv
      - rtl/apb_regs.sv
      - rtl/bnn_mac_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_bnn_mac.sv

// File: testbench/tb_bnn_mac.sv
`default_nettype none

module tb_bnn_mac
  import mac_regs_pkg::*;
();

  // Runs started over the whole test
  localparam int NUM_RUNS        = 8;
  localparam int POLL_LIMIT      = 200;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * 200 + 2000;
  localparam logic [APB_AW-1:0] ADDR_UNMAPPED = 8'h0c;
  localparam logic [APB_AW-1:0] ADDR_PAST_MEM = 8'h80;
  localparam logic [31:0]       ALL_DONE      = 32'((1 << NUM_PE) - 1);

  logic              clk;
  logic              reset;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pslverr;

  // Expected response of the access in flight
  logic              check_data;
  logic [31:0]       exp_data;
  logic              exp_err;

  // Model of what the DUT was loaded with
  logic [31:0]       rng;
  logic [MEM_DW-1:0] pix_words [MEM_DEPTH];
  logic [31:0]       weight_regs [NUM_PE];
  int                run_len;

  tb_clock u_clock (
    .clk (clk)
  );

  bnn_mac_top dut (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  ////////////////////////////////////////
  // Response checks
  ////////////////////////////////////////

  // Read data valid in the access phase
  property read_matches;
    @(posedge clk) disable iff (reset)
      (psel && penable && check_data) |-> (prdata == exp_data);
  endproperty

  // Checked in the access phase of reads and writes
  property slverr_matches;
    @(posedge clk) disable iff (reset)
      (psel && penable) |-> (pslverr == exp_err);
  endproperty

  prdata_check : assert property (read_matches)
    else stop_with_failure($sformatf("error: prdata at 0x%h is 0x%h, expected 0x%h",
                                     $sampled(paddr), $sampled(prdata), $sampled(exp_data)));

  pslverr_check : assert property (slverr_matches)
    else stop_with_failure($sformatf("error: pslverr at 0x%h is 0x%h, expected 0x%h",
                                     $sampled(paddr), $sampled(pslverr), $sampled(exp_err)));

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  // Hard limit on the whole run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("watchdog expired before the tests finished");
  end

  ////////////////////////////////////////
  // Model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Lanes 0,1 use weight 0, lanes 2,3 weight 1
  // Even lanes take pixel 0, odd lanes pixel 1
  function automatic logic [31:0] expected_lane(input int p, input int l);
    int         sum;
    logic       wbit;
    logic [7:0] px;
    sum = 0;
    for (int k = 0; k < run_len; k++) begin
      wbit = weight_regs[p][2 * k + l / 2];
      px   = (l % 2 == 1) ? pix_words[k][15:8] : pix_words[k][7:0];
      // Set bit is -1
      sum  = wbit ? sum - int'($signed(px)) : sum + int'($signed(px));
    end
    return 32'(sum);
  endfunction

  ////////////////////////////////////////
  // APB access
  ////////////////////////////////////////

  // Setup, access and release on falling edges
  task automatic apb_access(input logic [APB_AW-1:0] addr, input logic write,
                            input logic [31:0] wdata, input logic check,
                            input logic [31:0] expected, input logic err,
                            output logic [31:0] rd);
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable    = 1'b1;
    check_data = check;
    exp_data   = expected;
    exp_err    = err;
    @(negedge clk);
    rd         = prdata;
    psel       = 1'b0;
    penable    = 1'b0;
    check_data = 1'b0;
    exp_err    = 1'b0;
  endtask

  task automatic reg_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                           input logic err);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, 1'b0, '0, err, unused);
  endtask

  task automatic reg_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    apb_access(addr, 1'b0, '0, 1'b0, '0, 1'b0, data);
  endtask

  task automatic reg_read_check(input logic [APB_AW-1:0] addr, input logic [31:0] expected);
    logic [31:0] unused;
    apb_access(addr, 1'b0, '0, 1'b1, expected, 1'b0, unused);
  endtask

  // Read that must be refused with its data ignored
  task automatic reg_read_refused(input logic [APB_AW-1:0] addr);
    logic [31:0] unused;
    apb_access(addr, 1'b0, '0, 1'b0, '0, 1'b1, unused);
  endtask

  ////////////////////////////////////////
  // Loading and running
  ////////////////////////////////////////

  // LEN held in 1..MAX_LEN
  task automatic set_len(input int n);
    reg_write(ADDR_LEN, 32'(n), 1'b0);
    run_len = (n < 1) ? 1 : (n > MAX_LEN) ? MAX_LEN : n;
    reg_read_check(ADDR_LEN, 32'(run_len));
  endtask

  task automatic set_weights(input int p, input logic [31:0] w);
    reg_write(APB_AW'(ADDR_WEIGHT_BASE + 4 * p), w, 1'b0);
    weight_regs[p] = w;
    reg_read_check(APB_AW'(ADDR_WEIGHT_BASE + 4 * p), w);
  endtask

  task automatic random_weights;
    for (int p = 0; p < NUM_PE; p++) begin
      rng = xorshift32(rng);
      set_weights(p, rng);
    end
  endtask

  task automatic write_pixel_word(input int k, input logic [MEM_DW-1:0] word);
    reg_write(APB_AW'(ADDR_MEM_BASE + 4 * k), 32'(word), 1'b0);
    pix_words[k] = word;
  endtask

  task automatic fill_pixels(input logic [MEM_DW-1:0] word);
    for (int k = 0; k < MEM_DEPTH; k++) begin
      write_pixel_word(k, word);
    end
  endtask

  task automatic fill_random_pixels;
    for (int k = 0; k < MEM_DEPTH; k++) begin
      rng = xorshift32(rng);
      write_pixel_word(k, rng[MEM_DW-1:0]);
    end
  endtask

  // Poll STATUS at three cycles per read
  task automatic wait_done;
    logic [31:0] status;
    int          cycles;
    status = '0;
    cycles = 0;
    while (status != ALL_DONE && cycles < POLL_LIMIT) begin
      reg_read(ADDR_STATUS, status);
      cycles += 3;
    end
    if (status != ALL_DONE) begin
      stop_with_failure("engines still busy after 200 cycles of polling for done");
    end
  endtask

  task automatic run_engines;
    reg_write(ADDR_CTRL, 32'h1, 1'b0);
    wait_done();
  endtask

  // All eight accumulators against the model
  task automatic check_accumulators;
    for (int p = 0; p < NUM_PE; p++) begin
      for (int l = 0; l < 4; l++) begin
        reg_read_check(APB_AW'(ADDR_ACC_BASE + 4 * (4 * p + l)), expected_lane(p, l));
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    check_data = 1'b0;
    exp_data   = '0;
    exp_err    = 1'b0;
    rng        = 32'hac34;
    run_len    = 1;
    for (int k = 0; k < MEM_DEPTH; k++) begin
      pix_words[k] = '0;
    end
    for (int p = 0; p < NUM_PE; p++) begin
      weight_regs[p] = '0;
    end
    // Five rising edges in reset, release on the next falling edge
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle and cleared after reset
    reg_read_check(ADDR_STATUS, ALL_DONE);
    check_accumulators();
    reg_read_check(ADDR_LEN, 32'h1);
    for (int p = 0; p < NUM_PE; p++) begin
      reg_read_check(APB_AW'(ADDR_WEIGHT_BASE + 4 * p), 32'h0);
    end

    // Full random run with both engines contending
    fill_random_pixels();
    random_weights();
    set_len(MAX_LEN);
    run_engines();
    check_accumulators();

    // -128 times -1 everywhere
    fill_pixels(16'h8080);
    set_weights(0, '1);
    set_weights(1, '1);
    run_engines();
    check_accumulators();

    // +127 times +1 everywhere
    fill_pixels(16'h7f7f);
    set_weights(0, '0);
    set_weights(1, '0);
    run_engines();
    check_accumulators();

    // Pixel 1 at -128 over a negative pixel 0
    fill_pixels(16'h80ff);
    random_weights();
    run_engines();
    check_accumulators();

    // Single step
    fill_random_pixels();
    random_weights();
    set_len(1);
    run_engines();
    check_accumulators();

    // Restart with new weights clears the first sums
    set_len(MAX_LEN);
    fill_random_pixels();
    random_weights();
    run_engines();
    check_accumulators();
    random_weights();
    run_engines();
    check_accumulators();

    // Refused accesses during a run
    fill_random_pixels();
    random_weights();
    reg_write(ADDR_CTRL, 32'h1, 1'b0);
    reg_read_check(ADDR_STATUS, 32'h0);
    reg_read_refused(ADDR_UNMAPPED);
    reg_write(ADDR_STATUS, ALL_DONE, 1'b1);
    reg_write(ADDR_WEIGHT_BASE, ~weight_regs[0], 1'b1);
    // Last word is fetched late in the run
    reg_write(APB_AW'(ADDR_MEM_BASE + 4 * (MEM_DEPTH - 1)),
              32'(~pix_words[MEM_DEPTH-1]), 1'b1);
    reg_write(ADDR_LEN, 32'd3, 1'b1);
    // Start while busy is dropped quietly
    reg_write(ADDR_CTRL, 32'h1, 1'b0);
    wait_done();
    check_accumulators();
    reg_read_check(ADDR_WEIGHT_BASE, weight_regs[0]);
    reg_read_check(ADDR_LEN, 32'(run_len));

    // Refused accesses while idle
    reg_write(ADDR_UNMAPPED, 32'h1, 1'b1);
    reg_write(ADDR_ACC_BASE, 32'h1, 1'b1);
    reg_read_refused(ADDR_PAST_MEM);

    // LEN clamping
    set_len(0);
    set_len(40);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int PERIOD = 20;

  // Free running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: rtl/bnn_mac_top.sv
`default_nettype none

module bnn_mac_top
  import mac_arith_pkg::*;
  import mac_regs_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire  [APB_AW-1:0] paddr,
  input  wire               psel,
  input  wire               penable,
  input  wire               pwrite,
  input  wire  [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pslverr
);

  logic                                       start;
  logic [LEN_W-1:0]                           len;
  logic [NUM_PE-1:0][WEIGHT_W-1:0]            weights;
  logic                                       mem_we;
  logic [MEM_AW-1:0]                          mem_waddr;
  logic [MEM_DW-1:0]                          mem_wdata;
  logic                                       mem_ren;
  logic [MEM_AW-1:0]                          mem_raddr;
  // Read data shared by all engines
  logic [MEM_DW-1:0]                          mem_rdata;
  logic [NUM_PE-1:0]                          req;
  logic [NUM_PE-1:0]                          gnt;
  logic [NUM_PE-1:0]                          rvalid;
  logic [NUM_PE-1:0][MEM_AW-1:0]              raddr;
  logic [NUM_PE-1:0]                          busy;
  logic [NUM_PE-1:0][NUM_LANES-1:0][ACC_W-1:0] acc;

  apb_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .busy      (busy),
    .acc       (acc),
    .start     (start),
    .len       (len),
    .weights   (weights),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

  pixel_mem u_mem (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .ren   (mem_ren),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

  mem_arbiter u_arb (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .raddr     (raddr),
    .gnt       (gnt),
    .mem_raddr (mem_raddr),
    .mem_ren   (mem_ren),
    .rvalid    (rvalid)
  );

  // Same pixel stream, own weights per engine
  for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
    pe_engine u_pe (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .len     (len),
      .weights (weights[p]),
      .gnt     (gnt[p]),
      .rvalid  (rvalid[p]),
      .rdata   (mem_rdata),
      .req     (req[p]),
      .raddr   (raddr[p]),
      .busy    (busy[p]),
      .acc     (acc[p])
    );
  end

endmodule

`default_nettype wire

// File: rtl/apb_regs.sv
`default_nettype none

module apb_regs
  import mac_arith_pkg::*;
  import mac_regs_pkg::*;
(
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire  [APB_AW-1:0]                           paddr,
  input  wire                                         psel,
  input  wire                                         penable,
  input  wire                                         pwrite,
  input  wire  [APB_DW-1:0]                           pwdata,
  output logic [APB_DW-1:0]                           prdata,
  output logic                                        pslverr,
  input  wire  [NUM_PE-1:0]                           busy,
  input  wire  [NUM_PE-1:0][NUM_LANES-1:0][ACC_W-1:0] acc,
  output logic                                        start,
  output logic [LEN_W-1:0]                            len,
  output logic [NUM_PE-1:0][WEIGHT_W-1:0]             weights,
  output logic                                        mem_we,
  output logic [MEM_AW-1:0]                           mem_waddr,
  output logic [MEM_DW-1:0]                           mem_wdata
);

  logic                  access;
  logic                  any_busy;
  logic                  aligned;
  logic                  is_ctrl;
  logic                  is_len;
  logic                  is_status;
  logic                  is_weight;
  logic                  is_acc;
  logic                  is_mem;
  logic                  err;
  logic                  wr_ok;
  logic [APB_AW-1:0]     w_off;
  logic [APB_AW-1:0]     a_off;
  logic [APB_AW-1:0]     m_off;
  logic [PE_IDX_W-1:0]   w_sel;
  logic [PE_IDX_W-1:0]   a_pe;
  logic [LANE_IDX_W-1:0] a_lane;
  logic [ACC_W-1:0]      acc_word;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign access   = psel && penable;
  assign any_busy = |busy;
  // Word accesses only
  assign aligned  = (paddr[1:0] == 2'b00);

  assign is_ctrl   = (paddr == ADDR_CTRL);
  assign is_len    = (paddr == ADDR_LEN);
  assign is_status = (paddr == ADDR_STATUS);
  assign is_weight = aligned && (paddr >= ADDR_WEIGHT_BASE) && (paddr < ADDR_WEIGHT_END);
  assign is_acc    = aligned && (paddr >= ADDR_ACC_BASE) && (paddr < ADDR_ACC_END);
  assign is_mem    = aligned && (paddr >= ADDR_MEM_BASE) && (paddr < ADDR_MEM_END);

  // Offsets into each window
  assign w_off  = paddr - ADDR_WEIGHT_BASE;
  assign a_off  = paddr - ADDR_ACC_BASE;
  assign m_off  = paddr - ADDR_MEM_BASE;
  assign w_sel  = w_off[PE_IDX_W+1:2];
  // Accumulator word 4p + l
  assign a_lane = a_off[LANE_IDX_W+1:2];
  assign a_pe   = a_off[LANE_IDX_W+PE_IDX_W+1:LANE_IDX_W+2];

  // Unmapped, read-only target, or config write during a run
  assign err = !(is_ctrl || is_len || is_status || is_weight || is_acc || is_mem)
             || (pwrite && (is_status || is_acc))
             || (pwrite && any_busy && (is_len || is_weight || is_mem));

  assign pslverr = access && err;
  assign wr_ok   = access && pwrite && !err;

  // Pixel memory write straight through on the access edge
  assign mem_we    = wr_ok && is_mem;
  assign mem_waddr = m_off[MEM_AW+1:2];
  assign mem_wdata = pwdata[MEM_DW-1:0];

  ////////////////////////////////////////
  // Readback
  ////////////////////////////////////////

  assign acc_word = acc[a_pe][a_lane];

  always_comb begin
    prdata = '0;
    if (is_len) begin
      prdata = {{(APB_DW - LEN_W){1'b0}}, len};
    end else if (is_status) begin
      // Done bit per engine
      prdata = {{(APB_DW - NUM_PE){1'b0}}, ~busy};
    end else if (is_weight) begin
      prdata = weights[w_sel];
    end else if (is_acc) begin
      prdata = {{(APB_DW - ACC_W){acc_word[ACC_W-1]}}, acc_word};
    end
  end

  // Config registers and start pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      start   <= 1'b0;
      len     <= LEN_W'(1);
      weights <= '0;
    end else begin
      // Start ignored quietly while running
      start <= wr_ok && is_ctrl && pwdata[0] && !any_busy;
      if (wr_ok && is_len) begin
        if (pwdata == '0) begin
          len <= LEN_W'(1);
        end else if (pwdata > APB_DW'(MAX_LEN)) begin
          len <= LEN_W'(MAX_LEN);
        end else begin
          len <= pwdata[LEN_W-1:0];
        end
      end
      if (wr_ok && is_weight) begin
        weights[w_sel] <= pwdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/pixel_mem.sv
`default_nettype none

module pixel_mem
  import mac_regs_pkg::*;
(
  input  wire               clk,
  input  wire               we,
  input  wire  [MEM_AW-1:0] waddr,
  input  wire  [MEM_DW-1:0] wdata,
  input  wire               ren,
  input  wire  [MEM_AW-1:0] raddr,
  output logic [MEM_DW-1:0] rdata
);

  // Pixel 1 in the upper byte, pixel 0 in the lower
  logic [MEM_DW-1:0] mem [MEM_DEPTH];

  // Loaded only over APB
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`default_nettype none

module mem_arbiter
  import mac_regs_pkg::*;
(
  input  wire                          clk,
  input  wire                          reset,
  input  wire  [NUM_PE-1:0]            req,
  input  wire  [NUM_PE-1:0][MEM_AW-1:0] raddr,
  output logic [NUM_PE-1:0]            gnt,
  output logic [MEM_AW-1:0]            mem_raddr,
  output logic                         mem_ren,
  output logic [NUM_PE-1:0]            rvalid
);

  logic [PE_IDX_W-1:0] last;
  logic [PE_IDX_W-1:0] win;
  logic                found;

  // Search starts one past the last winner
  always_comb begin
    int idx;
    found = 1'b0;
    win   = last;
    idx   = 0;
    for (int i = 1; i <= NUM_PE; i++) begin
      idx = (int'(last) + i) % NUM_PE;
      if (!found && req[idx]) begin
        found = 1'b1;
        win   = PE_IDX_W'(idx);
      end
    end
  end

  assign gnt       = found ? (NUM_PE'(1) << win) : '0;
  assign mem_ren   = found;
  assign mem_raddr = raddr[win];

  // Data comes back one cycle after the grant
  always_ff @(posedge clk) begin
    if (reset) begin
      // Engine 0 wins the first tie
      last   <= PE_IDX_W'(NUM_PE - 1);
      rvalid <= '0;
    end else begin
      rvalid <= gnt;
      if (found) begin
        last <= win;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/pe_engine.sv
`default_nettype none

module pe_engine
  import mac_arith_pkg::*;
  import mac_regs_pkg::*;
(
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               start,
  input  wire  [LEN_W-1:0]                  len,
  input  wire  [WEIGHT_W-1:0]               weights,
  input  wire                               gnt,
  input  wire                               rvalid,
  input  wire  [MEM_DW-1:0]                 rdata,
  output logic                              req,
  output logic [MEM_AW-1:0]                 raddr,
  output logic                              busy,
  output logic [NUM_LANES-1:0][ACC_W-1:0]   acc
);

  typedef enum logic [1:0] {st_idle, st_req, st_wait, st_drain} state_t;

  state_t               state;
  logic [LEN_W-1:0]     step;
  logic [1:0]           drain_cnt;
  logic                 last_step;
  logic                 start_ok;
  logic                 w0;
  logic                 w1;
  logic [PIXEL_W-1:0]   pix0;
  logic [PIXEL_W-1:0]   pix1;
  logic [MULT_A_W-1:0]  a_hi;
  logic [MULT_A_W-1:0]  a_lo;
  logic [MULT_A_W-1:0]  op_a;
  logic [MULT_B_W-1:0]  op_b;
  logic                 mac_en;

  assign req       = (state == st_req);
  assign raddr     = step[MEM_AW-1:0];
  assign busy      = (state != st_idle);
  assign last_step = (step == len - LEN_W'(1));
  assign start_ok  = start && (state == st_idle);

  ////////////////////////////////////////
  // Step sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      step      <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_req;
            step  <= '0;
          end
        end
        // Hold req and raddr until granted
        st_req: begin
          if (gnt) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (rvalid) begin
            if (last_step) begin
              state     <= st_drain;
              drain_cnt <= 2'(ACC_LATENCY - 1);
            end else begin
              state <= st_req;
              step  <= step + 1'b1;
            end
          end
        end
        // Let the last steps through pack, multiply and accumulate
        st_drain: begin
          if (drain_cnt == '0) begin
            state <= st_idle;
          end else begin
            drain_cnt <= drain_cnt - 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand packing
  ////////////////////////////////////////

  // Weight bits of this step, set means -1
  assign w0 = weights[2 * step];
  assign w1 = weights[2 * step + 1];

  // +-1 at bit 0 and +-1 at WEIGHT_SHIFT
  assign a_lo = w0 ? '1 : MULT_A_W'(1);
  assign a_hi = w1 ? {{(MULT_A_W - WEIGHT_SHIFT){1'b1}}, {WEIGHT_SHIFT{1'b0}}}
                   : (MULT_A_W'(1) << WEIGHT_SHIFT);

  assign pix0 = rdata[PIXEL_W-1:0];
  assign pix1 = rdata[MEM_DW-1:PIXEL_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      mac_en <= 1'b0;
    end else begin
      mac_en <= (state == st_wait) && rvalid;
    end
  end

  // Pixel 1 one field up, pixel 0 sign-extended below it
  always_ff @(posedge clk) begin
    op_a <= a_hi + a_lo;
    op_b <= {pix1, FIELD_W'(0)} + {{(MULT_B_W - PIXEL_W){pix0[PIXEL_W-1]}}, pix0};
  end

  packed_mac u_mac (
    .clk   (clk),
    .reset (reset),
    .clear (start_ok),
    .en    (mac_en),
    .op_a  (op_a),
    .op_b  (op_b),
    .acc   (acc)
  );

endmodule

`default_nettype wire

// File: rtl/packed_mac.sv
`default_nettype none

module packed_mac
  import mac_arith_pkg::*;
(
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             clear,
  input  wire                             en,
  input  wire  [MULT_A_W-1:0]             op_a,
  input  wire  [MULT_B_W-1:0]             op_b,
  output logic [NUM_LANES-1:0][ACC_W-1:0] acc
);

  logic signed [PROD_W-1:0] raw_prod;
  logic signed [PROD_W-1:0] a_ext;
  logic [PROD_W-1:0]        fix;
  logic                     b_wrap;
  logic [PROD_W-1:0]        prod;
  logic                     en_d;

  assign raw_prod = $signed(op_a) * $signed(op_b);
  assign a_ext    = $signed(op_a);

  // Pixel pair needs 19 bits when pixel 1 is -128 and pixel 0 negative
  // Upper byte then reads 0x7f with the pixel 0 sign set
  // Take back op_a * 2^18 that the lost top bit added
  assign b_wrap = !op_b[MULT_B_W-1] && (&op_b[MULT_B_W-2:FIELD_W]) && op_b[FIELD_W-1];
  assign fix    = b_wrap ? (a_ext <<< MULT_B_W) : '0;

  // Multiply register stage
  always_ff @(posedge clk) begin
    prod <= raw_prod - fix;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en_d <= 1'b0;
    end else begin
      en_d <= en;
    end
  end

  ////////////////////////////////////////
  // Lane accumulators
  ////////////////////////////////////////

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    logic [FIELD_W-1:0] field;
    logic               borrow;
    logic [ACC_W-1:0]   lane_acc;

    assign field = prod[l*FIELD_W +: FIELD_W];

    // A negative field below takes one from this one
    if (l == 0) begin : g_first
      assign borrow = 1'b0;
    end else begin : g_upper
      assign borrow = prod[l*FIELD_W-1];
    end

    // Clear wins over a pending step
    always_ff @(posedge clk) begin
      if (reset || clear) begin
        lane_acc <= '0;
      end else if (en_d) begin
        lane_acc <= lane_acc + {{(ACC_W - FIELD_W){field[FIELD_W-1]}}, field}
                    + ACC_W'(borrow);
      end
    end

    assign acc[l] = lane_acc;
  end

endmodule

`default_nettype wire

// File: rtl/mac_regs_pkg.sv
`default_nettype none

////////////////////////////////////////
// Register map and system sizes
////////////////////////////////////////

package mac_regs_pkg;

  // Engines sharing the pixel memory
  localparam int NUM_PE   = 2;
  localparam int PE_IDX_W = $clog2(NUM_PE);

  // Pixel memory, two pixels per word
  localparam int MEM_DEPTH = 16;
  localparam int MEM_AW    = 4;
  localparam int MEM_DW    = 16;

  // Run length, LEN register holds 1..MAX_LEN
  localparam int MAX_LEN  = 16;
  localparam int LEN_W    = $clog2(MAX_LEN + 1);
  // Two weight bits per step
  localparam int WEIGHT_W = 2 * MAX_LEN;

  // APB bus
  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  // Address map
  localparam logic [APB_AW-1:0] ADDR_CTRL        = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_LEN         = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_STATUS      = 8'h08;
  localparam logic [APB_AW-1:0] ADDR_WEIGHT_BASE = 8'h10;
  localparam logic [APB_AW-1:0] ADDR_ACC_BASE    = 8'h20;
  localparam logic [APB_AW-1:0] ADDR_MEM_BASE    = 8'h40;

  // First address past each window
  localparam logic [APB_AW-1:0] ADDR_WEIGHT_END = ADDR_WEIGHT_BASE + APB_AW'(4 * NUM_PE);
  localparam logic [APB_AW-1:0] ADDR_ACC_END    = ADDR_ACC_BASE + APB_AW'(4 * NUM_PE * 4);
  localparam logic [APB_AW-1:0] ADDR_MEM_END    = ADDR_MEM_BASE + APB_AW'(4 * MEM_DEPTH);

endpackage

`default_nettype wire

// File: rtl/mac_arith_pkg.sv
`default_nettype none

////////////////////////////////////////
// Packed multiply and lane accumulate
////////////////////////////////////////

package mac_arith_pkg;

  // Signed pixel, one per packed field
  localparam int PIXEL_W = 8;

  // One product field inside the wide product
  localparam int FIELD_W = 10;

  // Lane 0 is w0*p0, lane 1 is w0*p1, lane 2 is w1*p0, lane 3 is w1*p1
  localparam int NUM_LANES  = 4;
  localparam int LANE_IDX_W = $clog2(NUM_LANES);

  // Per-lane running sum
  localparam int ACC_W = 16;

  // Signed multiplier operand and product widths
  localparam int MULT_A_W = 24;
  localparam int MULT_B_W = 18;
  localparam int PROD_W   = MULT_A_W + MULT_B_W;

  // Second weight sits here in operand A
  localparam int WEIGHT_SHIFT = 20;

  // Returned data to accumulated result, pack + multiply + accumulate
  localparam int ACC_LATENCY = 3;

endpackage

`default_nettype wire
